//--- tb.f
+incdir+verif
hdl/tilemapPkg.sv
hdl/tileSequencer.sv
hdl/layerShifter.sv
hdl/layerMixer.sv
hdl/tilemapGenerator.sv
verif/tilemapTb.sv

//--- verif/tilemapVectors.svh
`ifndef TILEMAP_VECTORS_SVH
`define TILEMAP_VECTORS_SVH

// Fetch kinds for one layer in one slot
localparam logic [1:0] kindGap = 2'd0;
localparam logic [1:0] kindFixed = 2'd1;
localparam logic [1:0] kindRandom = 2'd2;

localparam int numSlots = 13;

// One slot of stimulus, a sliver fetched here is shown in the next slot
typedef struct packed {
	logic [1:0] aKind;
	tilemapPkg::tileSliver a;
	// Second A sliver offered right behind the first, lands one slot later
	logic [1:0] a2Kind;
	tilemapPkg::tileSliver a2;
	logic [1:0] bKind;
	tilemapPkg::tileSliver b;
	tilemapPkg::tilePixel bg;
	// Register write, driven in phase 2 of the slot
	logic wrValid;
	tilemapPkg::regWrite wr;
} slotEntry;

slotEntry vec [numSlots];

// Layer contents per displayed slot
tilemapPkg::tileSliver showA [numSlots + 2];
tilemapPkg::tileSliver showB [numSlots + 2];
logic showValidA [numSlots + 2];
logic showValidB [numSlots + 2];

function automatic slotEntry makeSlot(input logic [1:0] aKind, input logic [19:0] aWord,
		input logic [1:0] bKind, input logic [19:0] bWord, input logic [2:0] bgPri,
		input logic [7:0] bgColor, input logic wrValid, input tilemapPkg::regAddr addr,
		input logic [7:0] data);
	slotEntry e;
	e = '0;
	e.aKind = aKind;
	e.a = aWord;
	e.bKind = bKind;
	e.b = bWord;
	e.bg.pri = bgPri;
	e.bg.color = bgColor;
	e.bg.dot = bgColor[2:0];
	e.wrValid = wrValid;
	e.wr.addr = addr;
	e.wr.data = data;
	return e;
endfunction

////////////////////////////////////////////////////////////
// Slot table
////////////////////////////////////////////////////////////

// Sliver word is pattern in the top 12 bits, color in the low 8
task automatic loadVectors();
	// Quiet slot, then A priority 3
	vec[0] = makeSlot(kindGap, '0, kindGap, '0, 3'd0, 8'h10, 1'b1, tilemapPkg::REG_PRI_A, 8'd3);
	// Known dots 5 7 0 3 on layer A only
	vec[1] = makeSlot(kindFixed, 20'hC5D2A, kindGap, '0, 3'd1, 8'h21, 1'b0,
		tilemapPkg::REG_PRI_A, 8'd0);
	vec[2] = makeSlot(kindRandom, '0, kindGap, '0, 3'd2, 8'h32, 1'b0, tilemapPkg::REG_PRI_A, 8'd0);
	// Both layers, B raised above A
	vec[3] = makeSlot(kindRandom, '0, kindRandom, '0, 3'd1, 8'h43, 1'b1,
		tilemapPkg::REG_PRI_B, 8'd5);
	// A raised to a tie in the middle of the slot
	vec[4] = makeSlot(kindRandom, '0, kindRandom, '0, 3'd0, 8'h54, 1'b1,
		tilemapPkg::REG_PRI_A, 8'd5);
	// Flip on
	vec[5] = makeSlot(kindRandom, '0, kindRandom, '0, 3'd4, 8'h65, 1'b1, tilemapPkg::REG_CTRL, 8'd1);
	vec[6] = makeSlot(kindFixed, 20'hC5D2A, kindGap, '0, 3'd0, 8'h76, 1'b0,
		tilemapPkg::REG_PRI_A, 8'd0);
	// A withheld for one slot
	vec[7] = makeSlot(kindGap, '0, kindRandom, '0, 3'd0, 8'h87, 1'b1, tilemapPkg::REG_PRI_B, 8'd1);
	// Back to back A slivers, flip off
	vec[8] = makeSlot(kindRandom, '0, kindRandom, '0, 3'd0, 8'h98, 1'b1, tilemapPkg::REG_CTRL, 8'd0);
	vec[8].a2Kind = kindRandom;
	vec[9] = makeSlot(kindGap, '0, kindGap, '0, 3'd3, 8'hA9, 1'b0, tilemapPkg::REG_PRI_A, 8'd0);
	vec[10] = makeSlot(kindRandom, '0, kindRandom, '0, 3'd2, 8'hBA, 1'b0,
		tilemapPkg::REG_PRI_A, 8'd0);
	vec[11] = makeSlot(kindGap, '0, kindGap, '0, 3'd1, 8'hCB, 1'b1, tilemapPkg::REG_PRI_A, 8'd2);
	vec[12] = makeSlot(kindGap, '0, kindGap, '0, 3'd0, 8'hDC, 1'b0, tilemapPkg::REG_PRI_A, 8'd0);
endtask

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Slot rule, what each layer shows in each slot
task automatic planSlots();
	for (int i = 0; i < numSlots + 2; i++) begin
		showValidA[i] = 1'b0;
		showValidB[i] = 1'b0;
		showA[i] = '0;
		showB[i] = '0;
	end
	for (int i = 0; i < numSlots; i++) begin
		if (vec[i].aKind != kindGap) begin
			showValidA[i + 1] = 1'b1;
			showA[i + 1] = vec[i].a;
		end
		// Blocked until the next reload, so one slot later
		if (vec[i].a2Kind != kindGap) begin
			showValidA[i + 2] = 1'b1;
			showA[i + 2] = vec[i].a2;
		end
		if (vec[i].bKind != kindGap) begin
			showValidB[i + 1] = 1'b1;
			showB[i + 1] = vec[i].b;
		end
	end
endtask

// Pixel p of a sliver, bit 3 first unless flipped
function automatic logic [2:0] dotAt(input tilemapPkg::tileSliver s, input int p,
		input logic flip);
	int bitPos;
	bitPos = flip ? p : tilemapPkg::sliverPixels - 1 - p;
	return {s.pattern[2 * tilemapPkg::sliverPixels + bitPos],
		s.pattern[tilemapPkg::sliverPixels + bitPos], s.pattern[bitPos]};
endfunction

function automatic tilemapPkg::tilePixel layerPixel(input logic shown,
		input tilemapPkg::tileSliver s, input int p, input logic flip,
		input logic [2:0] pri);
	tilemapPkg::tilePixel px;
	px = '0;
	px.pri = pri;
	px.color = s.color;
	// Nothing loaded means see-through for the whole slot
	px.dot = shown ? dotAt(s, p, flip) : tilemapPkg::transparentDot;
	return px;
endfunction

// Opaque layer with the higher priority, A on a tie, must beat the background
function automatic tilemapPkg::tilePixel mixPixels(input tilemapPkg::tilePixel a,
		input tilemapPkg::tilePixel b, input tilemapPkg::tilePixel bg, input logic first);
	tilemapPkg::tilePixel w;
	tilemapPkg::tilePixel r;
	logic aOn;
	logic bOn;
	aOn = (a.dot != tilemapPkg::transparentDot);
	bOn = (b.dot != tilemapPkg::transparentDot);
	if (aOn && bOn) begin
		w = (b.pri > a.pri) ? b : a;
	end else begin
		w = aOn ? a : b;
	end
	r = ((aOn || bOn) && (w.pri > bg.pri)) ? w : bg;
	r.first = first;
	return r;
endfunction

// Background for pixel p, first bit inverted on purpose
function automatic tilemapPkg::tilePixel bgFor(input tilemapPkg::tilePixel base, input int p);
	tilemapPkg::tilePixel px;
	px = base;
	px.color = base.color ^ 8'(p);
	px.first = (p != 0);
	return px;
endfunction

`endif

//--- verif/tilemapTb.sv
module tilemapTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic CLK_6M;
	logic rst;
	tilemapPkg::tileSliver fetchA;
	logic fetchAValid;
	logic fetchAReady;
	tilemapPkg::tileSliver fetchB;
	logic fetchBValid;
	logic fetchBReady;
	tilemapPkg::regWrite cpuWr;
	logic cpuWrValid;
	tilemapPkg::tilePixel bgIn;
	tilemapPkg::tilePixel pixOut;

	int pixErrors = 0;
	int readyErrors = 0;
	int cycleCount = 0;
	// Random generator state
	logic [31:0] rngState;

	`include "tilemapVectors.svh"

	// Reset plus every slot, with margin
	localparam int cycleLimit = 4 * (numSlots + 4) + 40;

	tilemapGenerator DUT (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.fetchA(fetchA),
		.fetchAValid(fetchAValid),
		.fetchAReady(fetchAReady),
		.fetchB(fetchB),
		.fetchBValid(fetchBValid),
		.fetchBReady(fetchBReady),
		.cpuWr(cpuWr),
		.cpuWrValid(cpuWrValid),
		.bgIn(bgIn),
		.pixOut(pixOut)
	);

	// 4 ns pixel clock
	always begin
		#2 CLK_6M = ~CLK_6M;
	end

	// Run limit
	always @(posedge CLK_6M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run reached %0d cycles before the slot loop ended", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Random fill
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic tilemapPkg::tileSliver randomSliver();
		logic [31:0] r;
		tilemapPkg::tileSliver s;
		r = xorshift32();
		s.pattern = r[31:20];
		s.color = r[7:0];
		return s;
	endfunction

	// Fill random table fields, in table order
	task automatic resolveRandom();
		for (int i = 0; i < numSlots; i++) begin
			if (vec[i].aKind == kindRandom) vec[i].a = randomSliver();
			if (vec[i].a2Kind == kindRandom) vec[i].a2 = randomSliver();
			if (vec[i].bKind == kindRandom) vec[i].b = randomSliver();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic checkPixel(input string name, input tilemapPkg::tilePixel got,
			input tilemapPkg::tilePixel exp);
		if (got !== exp) begin
			pixErrors++;
			$display("** Error at %t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkReady(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			readyErrors++;
			$display("** Error at %t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus loop
	////////////////////////////////////////////////////////////

	initial begin
		tilemapPkg::tilePixel expPrev;
		tilemapPkg::tilePixel expNow;
		tilemapPkg::tilePixel layA;
		tilemapPkg::tilePixel layB;
		slotEntry cur;
		logic tookA;
		logic tookB;
		logic pendA2;
		logic [2:0] mPriA;
		logic [2:0] mPriB;
		logic mFlip;
		logic mFlipSlot;

		$timeformat(-9, 1, " ns", 10);
		CLK_6M = 1'b0;
		rst = 1'b1;
		fetchA = '0;
		fetchAValid = 1'b0;
		fetchB = '0;
		fetchBValid = 1'b0;
		cpuWr = '0;
		cpuWrValid = 1'b0;
		bgIn = '0;
		rngState = 32'd83;
		loadVectors();
		resolveRandom();
		planSlots();
		// Output register clears in reset
		expPrev = '0;
		tookA = 1'b0;
		tookB = 1'b0;
		pendA2 = 1'b0;
		mPriA = '0;
		mPriB = '0;
		mFlip = 1'b0;
		mFlipSlot = 1'b0;

		repeat (10) @(posedge CLK_6M);
		rst <= 1'b0;
		// Phase 0 starts in the first cycle out of reset
		for (int s = 0; s < numSlots; s++) begin
			cur = vec[s];
			for (int p = 0; p < tilemapPkg::sliverPixels; p++) begin
				bgIn <= bgFor(cur.bg, p);
				// Offer at slot start, hold until Ready was seen
				if (p == 0 && cur.aKind != kindGap) begin
					fetchA <= cur.a;
					fetchAValid <= 1'b1;
					pendA2 = (cur.a2Kind != kindGap);
				end else if (tookA) begin
					if (pendA2) begin
						fetchA <= cur.a2;
						pendA2 = 1'b0;
					end else begin
						fetchAValid <= 1'b0;
					end
				end
				if (p == 0 && cur.bKind != kindGap) begin
					fetchB <= cur.b;
					fetchBValid <= 1'b1;
				end else if (tookB) begin
					fetchBValid <= 1'b0;
				end
				// Register write lands at the end of phase 2
				cpuWrValid <= (p == 2) ? cur.wrValid : 1'b0;
				cpuWr <= cur.wr;

				@(negedge CLK_6M);
				layA = layerPixel(showValidA[s], showA[s], p, mFlipSlot, mPriA);
				layB = layerPixel(showValidB[s], showB[s], p, mFlipSlot, mPriB);
				expNow = mixPixels(layA, layB, bgIn, p == 0);
				// Output trails the mix by one cycle
				checkPixel("pixOut", pixOut, expPrev);
				// Full from the transfer at phase 0 until reload
				checkReady("fetchAReady", fetchAReady, !(showValidA[s + 1] && p != 0));
				checkReady("fetchBReady", fetchBReady, !(showValidB[s + 1] && p != 0));
				expPrev = expNow;
				tookA = fetchAValid && fetchAReady;
				tookB = fetchBValid && fetchBReady;
				if (p == 2 && cur.wrValid) begin
					case (cur.wr.addr)
						tilemapPkg::REG_PRI_A: mPriA = cur.wr.data[2:0];
						tilemapPkg::REG_PRI_B: mPriB = cur.wr.data[2:0];
						tilemapPkg::REG_CTRL: mFlip = cur.wr.data[0];
						default: ;
					endcase
				end
				// Flip taken at reload
				if (p == tilemapPkg::sliverPixels - 1) mFlipSlot = mFlip;
				@(posedge CLK_6M);
			end
		end
		@(negedge CLK_6M);
		checkPixel("pixOut", pixOut, expPrev);

		$display("Check summary: %0d pixel errors, %0d ready errors", pixErrors, readyErrors);
		if (pixErrors + readyErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- hdl/tilemapGenerator.sv
module tilemapGenerator (
	input logic CLK_6M,
	input logic rst,
	// Layer A fetch
	input tilemapPkg::tileSliver fetchA,
	input logic fetchAValid,
	output logic fetchAReady,
	// Layer B fetch
	input tilemapPkg::tileSliver fetchB,
	input logic fetchBValid,
	output logic fetchBReady,
	// CPU writes
	input tilemapPkg::regWrite cpuWr,
	input logic cpuWrValid,
	// Pixel chain
	input tilemapPkg::tilePixel bgIn,
	output tilemapPkg::tilePixel pixOut
);

	logic reload;
	logic firstPix;
	tilemapPkg::layerCtl ctlA;
	tilemapPkg::layerCtl ctlB;
	tilemapPkg::tilePixel pixA;
	tilemapPkg::tilePixel pixB;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	tileSequencer seq (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.fetchAValid(fetchAValid),
		.fetchBValid(fetchBValid),
		.fetchAReady(fetchAReady),
		.fetchBReady(fetchBReady),
		.cpuWr(cpuWr),
		.cpuWrValid(cpuWrValid),
		.reload(reload),
		.firstPix(firstPix),
		.ctlA(ctlA),
		.ctlB(ctlB)
	);

	////////////////////////////////////////////////////////////
	// Layers
	////////////////////////////////////////////////////////////

	// Layer A
	layerShifter shiftA (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.fetch(fetchA),
		.fetchValid(fetchAValid),
		.fetchReady(fetchAReady),
		.reload(reload),
		.ctl(ctlA),
		.pix(pixA)
	);

	// Layer B
	layerShifter shiftB (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.fetch(fetchB),
		.fetchValid(fetchBValid),
		.fetchReady(fetchBReady),
		.reload(reload),
		.ctl(ctlB),
		.pix(pixB)
	);

	// Priority mix against the chain input
	layerMixer mix (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.pixA(pixA),
		.pixB(pixB),
		.bgIn(bgIn),
		.firstPix(firstPix),
		.pixOut(pixOut)
	);

endmodule

//--- hdl/layerMixer.sv
module layerMixer (
	input logic CLK_6M,
	input logic rst,
	// Layer pixels and the chain input
	input tilemapPkg::tilePixel pixA,
	input tilemapPkg::tilePixel pixB,
	input tilemapPkg::tilePixel bgIn,
	// Slot start from the sequencer
	input logic firstPix,
	output tilemapPkg::tilePixel pixOut
);

	logic opaqueA;
	logic opaqueB;
	logic haveWinner;
	tilemapPkg::tilePixel winner;
	tilemapPkg::tilePixel mixed;

	////////////////////////////////////////////////////////////
	// Layer against layer
	////////////////////////////////////////////////////////////

	assign opaqueA = (pixA.dot != tilemapPkg::transparentDot);
	assign opaqueB = (pixB.dot != tilemapPkg::transparentDot);
	assign haveWinner = opaqueA | opaqueB;

	// A takes ties
	always_comb begin
		if (opaqueA && (!opaqueB || (pixA.pri >= pixB.pri))) begin
			winner = pixA;
		end else begin
			winner = pixB;
		end
	end

	////////////////////////////////////////////////////////////
	// Winner against background
	////////////////////////////////////////////////////////////

	// Layer must strictly beat the chain input
	always_comb begin
		if (haveWinner && (winner.pri > bgIn.pri)) begin
			mixed = winner;
		end else begin
			mixed = bgIn;
		end
		// Slot marker comes from our own phase
		mixed.first = firstPix;
	end

	// One pipeline stage to the output
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pixOut <= '0;
		end else begin
			pixOut <= mixed;
		end
	end

endmodule

//--- hdl/layerShifter.sv
module layerShifter (
	input logic CLK_6M,
	input logic rst,
	// Sliver from the fetch unit
	input tilemapPkg::tileSliver fetch,
	input logic fetchValid,
	input logic fetchReady,
	// Slot boundary from the sequencer
	input logic reload,
	input tilemapPkg::layerCtl ctl,
	// Current pixel of this layer
	output tilemapPkg::tilePixel pix
);

	// Plane fill that reads back as a see-through dot
	localparam logic [tilemapPkg::sliverPixels-1:0] clearPlane0 =
		{tilemapPkg::sliverPixels{tilemapPkg::transparentDot[0]}};
	localparam logic [tilemapPkg::sliverPixels-1:0] clearPlane1 =
		{tilemapPkg::sliverPixels{tilemapPkg::transparentDot[1]}};
	localparam logic [tilemapPkg::sliverPixels-1:0] clearPlane2 =
		{tilemapPkg::sliverPixels{tilemapPkg::transparentDot[2]}};

	////////////////////////////////////////////////////////////
	// Holding register
	////////////////////////////////////////////////////////////

	tilemapPkg::tileSliver holdSliver;
	logic holdValid;

	// Capture on transfer
	always_ff @(posedge CLK_6M) begin
		if (fetchValid && fetchReady) begin
			holdSliver <= fetch;
		end
	end

	// Mirrors the sequencer flag for this layer
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			holdValid <= 1'b0;
		end else begin
			holdValid <= (holdValid & ~reload) | (fetchValid & fetchReady);
		end
	end

	////////////////////////////////////////////////////////////
	// Plane shifters
	////////////////////////////////////////////////////////////

	logic [tilemapPkg::sliverPixels-1:0] plane0;
	logic [tilemapPkg::sliverPixels-1:0] plane1;
	logic [tilemapPkg::sliverPixels-1:0] plane2;
	logic [tilemapPkg::colorWidth-1:0] color;
	// Flip as sampled at the last reload
	logic flipSlot;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			plane0 <= clearPlane0;
			plane1 <= clearPlane1;
			plane2 <= clearPlane2;
			flipSlot <= 1'b0;
		end else if (reload) begin
			flipSlot <= ctl.flip;
			if (holdValid) begin
				plane0 <= holdSliver.pattern[3:0];
				plane1 <= holdSliver.pattern[7:4];
				plane2 <= holdSliver.pattern[11:8];
			end else begin
				// Nothing fetched so the whole slot is see-through
				plane0 <= clearPlane0;
				plane1 <= clearPlane1;
				plane2 <= clearPlane2;
			end
		end else begin
			// Flipped slots walk from bit 0 up
			if (flipSlot) begin
				plane0 <= {clearPlane0[0], plane0[3:1]};
				plane1 <= {clearPlane1[0], plane1[3:1]};
				plane2 <= {clearPlane2[0], plane2[3:1]};
			end else begin
				plane0 <= {plane0[2:0], clearPlane0[0]};
				plane1 <= {plane1[2:0], clearPlane1[0]};
				plane2 <= {plane2[2:0], clearPlane2[0]};
			end
		end
	end

	// Attribute follows the sliver into the shifters
	always_ff @(posedge CLK_6M) begin
		if (reload && holdValid) begin
			color <= holdSliver.color;
		end
	end

	// Current pixel with the tap set by the shift direction
	always_comb begin
		pix.pri = ctl.pri;
		pix.color = color;
		if (flipSlot) begin
			pix.dot = {plane2[0], plane1[0], plane0[0]};
		end else begin
			pix.dot = {plane2[3], plane1[3], plane0[3]};
		end
		// Slot marker is added by the mixer
		pix.first = 1'b0;
	end

endmodule

//--- hdl/tileSequencer.sv
module tileSequencer (
	input logic CLK_6M,
	input logic rst,
	// Fetch handshakes
	// Sliver data goes straight to the shifters
	input logic fetchAValid,
	input logic fetchBValid,
	output logic fetchAReady,
	output logic fetchBReady,
	// CPU register port
	input tilemapPkg::regWrite cpuWr,
	input logic cpuWrValid,
	// Slot timing
	output logic reload,
	output logic firstPix,
	// Layer controls
	output tilemapPkg::layerCtl ctlA,
	output tilemapPkg::layerCtl ctlB
);

	////////////////////////////////////////////////////////////
	// Slot phase
	////////////////////////////////////////////////////////////

	// Pixel position within the current slot
	logic [tilemapPkg::phaseWidth-1:0] phase;

	// Free running counter that wraps every sliver
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			phase <= '0;
		end else if (phase == tilemapPkg::phaseWidth'(tilemapPkg::sliverPixels - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Last pixel of the slot
	// Shifters load on the edge that ends it
	assign reload = (phase == tilemapPkg::phaseWidth'(tilemapPkg::sliverPixels - 1));
	// First pixel of the slot
	assign firstPix = (phase == '0);

	////////////////////////////////////////////////////////////
	// Holding register occupancy
	////////////////////////////////////////////////////////////

	// Set while a sliver waits for the next reload
	logic holdFullA;
	logic holdFullB;

	// Accept only into an empty holding register
	assign fetchAReady = ~holdFullA;
	assign fetchBReady = ~holdFullB;

	// Reload empties the register and a transfer on the same edge refills it
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			holdFullA <= 1'b0;
			holdFullB <= 1'b0;
		end else begin
			holdFullA <= (holdFullA & ~reload) | (fetchAValid & fetchAReady);
			holdFullB <= (holdFullB & ~reload) | (fetchBValid & fetchBReady);
		end
	end

	////////////////////////////////////////////////////////////
	// CPU registers
	////////////////////////////////////////////////////////////

	logic [tilemapPkg::priWidth-1:0] priA;
	logic [tilemapPkg::priWidth-1:0] priB;
	// Horizontal flip shared by both layers
	logic flip;

	// Write lands on the edge and reaches the mixer next cycle
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			priA <= '0;
			priB <= '0;
			flip <= 1'b0;
		end else if (cpuWrValid) begin
			case (cpuWr.addr)
				tilemapPkg::REG_PRI_A: begin
					priA <= cpuWr.data[tilemapPkg::priWidth-1:0];
				end
				tilemapPkg::REG_PRI_B: begin
					priB <= cpuWr.data[tilemapPkg::priWidth-1:0];
				end
				tilemapPkg::REG_CTRL: begin
					flip <= cpuWr.data[0];
				end
				default: begin
					// Unmapped address is ignored
				end
			endcase
		end
	end

	// Pack per-layer controls
	always_comb begin
		ctlA.pri = priA;
		ctlA.flip = flip;
		ctlB.pri = priB;
		ctlB.flip = flip;
	end

endmodule

//--- hdl/tilemapPkg.sv
package tilemapPkg;

	////////////////////////////////////////////////////////////
	// Pixel and sliver geometry
	////////////////////////////////////////////////////////////

	// Dot index is three planes, one bit each
	localparam int pixelWidthDot = 3;
	// Color attribute goes on to the palette stage
	localparam int colorWidth = 8;
	// Priority compared against the other layer and the chain input
	localparam int priWidth = 3;
	// Pixels per sliver, equal to one slot in clocks
	localparam int sliverPixels = 4;
	// Width of the slot phase counter
	localparam int phaseWidth = $clog2(sliverPixels);
	// See-through dot value, all planes set
	localparam logic [pixelWidthDot-1:0] transparentDot = 3'd7;

	// Pattern word holds one plane per nibble
	localparam int patternWidth = pixelWidthDot * sliverPixels;

	////////////////////////////////////////////////////////////
	// Pixel as it travels down the chain
	////////////////////////////////////////////////////////////

	// Same layout for the background input and the final output
	typedef struct packed {
		logic [priWidth-1:0] pri;
		logic [colorWidth-1:0] color;
		logic [pixelWidthDot-1:0] dot;
		// Marks the first pixel of a slot
		logic first;
	} tilePixel;

	// One fetched tile sliver
	// Plane 0 in pattern[3:0], plane 1 in [7:4], plane 2 in [11:8]
	typedef struct packed {
		logic [patternWidth-1:0] pattern;
		logic [colorWidth-1:0] color;
	} tileSliver;

	////////////////////////////////////////////////////////////
	// CPU register port
	////////////////////////////////////////////////////////////

	// Register select
	typedef enum logic [1:0] {
		REG_PRI_A = 2'd0,
		REG_PRI_B = 2'd1,
		REG_CTRL  = 2'd2
	} regAddr;

	// One register write, priority taken from data[2:0], flip from data[0]
	typedef struct packed {
		regAddr addr;
		logic [7:0] data;
	} regWrite;

	// Per-layer control handed from the sequencer to a shifter
	typedef struct packed {
		logic [priWidth-1:0] pri;
		logic flip;
	} layerCtl;

endpackage
